//--- u3v_stream.f
common/u3v_pkg.sv
common/stream_pkg.sv
header_gen/u3v_leader.sv
header_gen/u3v_trailer.sv
verilog/chunk_appender.sv
verilog/frame_sequencer.sv
verilog/u3v_stream.sv
tb/tb_clock.sv
tb/tb_u3v_stream.sv

//--- Makefile
SRCS := $(shell cat u3v_stream.f)

.PHONY: run clean

obj_dir/sim: u3v_stream.f $(SRCS)
	verilator --binary --timing --assert -sv --top-module tb_u3v_stream \
		-f u3v_stream.f -Mdir obj_dir -o sim

run: obj_dir/sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf obj_dir

//--- tb/tb_u3v_stream.sv
module tb_u3v_stream;
	timeunit 1ns;
	timeprecision 1ps;
	import stream_pkg::*;
	import u3v_pkg::*;

	localparam int N_FRAMES = 10;

	logic         clk;
	logic         reset;
	frame_cfg_t   i_cfg;
	logic [63:0]  i_timestamp;
	logic         i_frame_start;
	stream_word_t i_pixel;
	logic         i_frame_end;
	stream_word_t o_stream;
	logic         o_busy;

	logic [31:0] rng;	// xorshift state
	logic [31:0] got[$];	// words seen on o_stream
	logic [63:0] block_id_exp;
	logic [7:0]  layout_changes;	// enable changes, mod 256
	int          npix_list[N_FRAMES];
	int          errors;
	int          tests;
	int          bad_tests;
	int          cycles;
	int          cycle_limit;

	tb_clock clkgen (.o_clk(clk), .o_reset(reset));

	u3v_stream #(.PAYLOAD_CNT_WD(24)) UUT (
		.clk(clk), .reset(reset), .i_cfg(i_cfg), .i_timestamp(i_timestamp),
		.i_frame_start(i_frame_start), .i_pixel(i_pixel), .i_frame_end(i_frame_end),
		.o_stream(o_stream), .o_busy(o_busy)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic string section_of(input int idx, input int npix, input int clen);
		if (idx < 13) return "leader";
		if (idx < 13 + npix) return "payload";
		if (idx < 13 + npix + clen) return "chunk";
		return "trailer";
	endfunction

	// ----------------------------------------
	// free-running timestamp, monitor, timeout
	// ----------------------------------------
	always @(negedge clk) i_timestamp <= i_timestamp + 64'd1;

	always @(negedge clk) begin
		if (!reset && o_stream.valid) got.push_back(o_stream.data);	// stable mid-cycle
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run stopped after %0d cycles, a frame never finished", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// magic lands on o_stream at the 3rd edge after the start edge
	// so the sampled value shows it one edge later
	a_leader_latency: assert property (@(posedge clk) disable iff (reset)
		(i_frame_start && !o_busy) |-> ##4 (o_stream.valid && o_stream.data == 32'h4C563355))
	else begin
		$display("FAIL t=%0t leader magic not on o_stream 3 cycles after start", $time);
		errors++;
	end

	// drive enables for one cycle, counting real changes
	task automatic set_enables(input logic [2:0] en);
		@(negedge clk);
		if (en != {i_cfg.chunk_mode_active, i_cfg.chunkid_en_ts, i_cfg.chunkid_en_fid})
			layout_changes = layout_changes + 8'd1;
		{i_cfg.chunk_mode_active, i_cfg.chunkid_en_ts, i_cfg.chunkid_en_fid} = en;
	endtask

	// ----------------------------------------
	// one frame, built and checked
	// ----------------------------------------
	task automatic run_frame(input string name, input logic [2:0] en, input int npix,
		input int expw, input bit busy_start);
		logic [31:0] exp_q[$];
		logic [63:0] ts_exp;
		logic [31:0] vps;
		logic [15:0] status;
		int          clen;
		int          errs_before;
		errs_before = errors;
		set_enables(en);
		rng = xorshift(rng);
		i_cfg.pixel_format = rng;
		{i_cfg.size_x, i_cfg.size_y} = xorshift(rng);
		rng = xorshift(xorshift(rng));
		{i_cfg.offset_x, i_cfg.offset_y} = rng;
		i_cfg.padding_x = rng[23:8];
		i_cfg.expected_words = 32'(expw);
		repeat (2) @(negedge clk);
		got.delete();
		i_frame_start = 1'b1;
		@(posedge clk);
		ts_exp = i_timestamp;	// value the DUT latches on this edge
		@(negedge clk);
		i_frame_start = 1'b0;
		// leader block
		exp_q.push_back(32'h4C563355);
		exp_q.push_back({16'd52, 16'h0});
		exp_q.push_back(block_id_exp[31:0]);
		exp_q.push_back(block_id_exp[63:32]);
		exp_q.push_back(en[2] ? 32'h4001 : 32'h0001);
		exp_q.push_back(ts_exp[31:0]);
		exp_q.push_back(ts_exp[63:32]);
		exp_q.push_back(i_cfg.pixel_format);
		exp_q.push_back({16'h0, i_cfg.size_x});
		exp_q.push_back({16'h0, i_cfg.size_y});
		exp_q.push_back({16'h0, i_cfg.offset_x});
		exp_q.push_back({16'h0, i_cfg.offset_y});
		exp_q.push_back({16'h0, i_cfg.padding_x});
		repeat (2) @(negedge clk);
		if (!o_busy) begin
			$display("missing frame: busy never rose after the start pulse in %s", name);
			errors++;
		end
		repeat (17) @(negedge clk);	// leader phase over by now
		for (int i = 0; i < npix; i++) begin
			rng = xorshift(rng);
			i_pixel.valid = 1'b1;
			i_pixel.data = rng;
			i_frame_end = (i == npix - 1);
			i_frame_start = busy_start && (i == npix / 2);	// must be ignored
			exp_q.push_back(rng);
			@(negedge clk);
		end
		i_pixel.valid = 1'b0;
		i_frame_end = 1'b0;
		i_frame_start = 1'b0;
		vps = 32'(npix * 4);
		status = (npix < expw) ? STATUS_SHORT : 16'h0000;
		clen = 0;
		if (en[2]) begin
			exp_q.push_back(CHUNK_ID_IMAGE);
			exp_q.push_back(vps);
			clen = 2;
			if (en[1]) begin
				exp_q.push_back(ts_exp[31:0]);
				exp_q.push_back(ts_exp[63:32]);
				exp_q.push_back(CHUNK_ID_TS);
				exp_q.push_back(32'd8);
				clen += 4;
			end
			if (en[0]) begin
				exp_q.push_back(block_id_exp[31:0]);
				exp_q.push_back(block_id_exp[63:32]);
				exp_q.push_back(CHUNK_ID_FID);
				exp_q.push_back(32'd8);
				clen += 4;
			end
		end
		// trailer block
		exp_q.push_back(32'h54563355);
		exp_q.push_back({(en[2] ? 16'd36 : 16'd32), 16'h0});
		exp_q.push_back(block_id_exp[31:0]);
		exp_q.push_back(block_id_exp[63:32]);
		exp_q.push_back({16'h0, status});
		exp_q.push_back(vps);
		exp_q.push_back(32'h0);
		exp_q.push_back({16'h0, i_cfg.size_y});
		if (en[2]) exp_q.push_back({24'h0, layout_changes});
		while (o_busy) @(negedge clk);	// global counter guards this
		@(negedge clk);
		assert (got.size() == exp_q.size())
		else begin
			$display("FAIL t=%0t %s: %0d words on o_stream, expected %0d",
				$time, name, got.size(), exp_q.size());
			errors++;
		end
		for (int i = 0; i < exp_q.size() && i < got.size(); i++) begin
			assert (got[i] === exp_q[i])
			else begin
				$display("FAIL t=%0t %s: %s word %0d is %h, expected %h",
					$time, name, section_of(i, npix, clen), i, got[i], exp_q[i]);
				errors++;
			end
		end
		block_id_exp = block_id_exp + 64'd1;
		tests++;
		if (errors != errs_before) bad_tests++;
		$display("test %0d %s: %0d pixel words, %s", tests, name, npix,
			(errors == errs_before) ? "ok" : "bad");
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		logic [2:0] en;
		int         total;
		i_cfg = '0;
		i_timestamp = 64'h0000_0001_FFFF_FF00;	// high word rolls over early
		i_frame_start = 1'b0;
		i_pixel = '0;
		i_frame_end = 1'b0;
		rng = 32'd92866;
		block_id_exp = 64'd0;
		layout_changes = 8'd0;
		errors = 0;
		tests = 0;
		bad_tests = 0;
		cycles = 0;
		total = 20;
		for (int i = 0; i < N_FRAMES; i++) begin
			rng = xorshift(rng);
			npix_list[i] = 8 + int'(rng % 33);
			total += npix_list[i] + 60;	// setup, leader, chunk, trailer, gap
		end
		cycle_limit = 2 * total;
		@(negedge reset);
		repeat (3) @(negedge clk);

		run_frame("image mode", 3'b000, npix_list[0], npix_list[0], 1'b0);
		run_frame("image mode, enables ignored", 3'b011, npix_list[1], npix_list[1], 1'b0);
		run_frame("chunk only image tag", 3'b100, npix_list[2], npix_list[2], 1'b0);
		run_frame("chunk with timestamp", 3'b110, npix_list[3], npix_list[3], 1'b0);
		run_frame("chunk with frame id", 3'b101, npix_list[4], npix_list[4], 1'b0);
		run_frame("chunk with both", 3'b111, npix_list[5], npix_list[5], 1'b0);
		// random enable toggles between frames
		for (int k = 6; k < 9; k++) begin
			rng = xorshift(rng);
			set_enables(rng[2:0]);
			set_enables(rng[5:3]);
			en = {1'b1, rng[7:6]};
			run_frame("layout id after toggles", en, npix_list[k], npix_list[k], 1'b0);
		end
		run_frame("short frame, busy start", 3'b000, npix_list[9], npix_list[9] + 5, 1'b1);

		$display("tests %0d, bad %0d, errors %0d", tests, bad_tests, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- tb/tb_clock.sv
module tb_clock (
	output logic o_clk,
	output logic o_reset
);
	timeunit 1ns;
	timeprecision 1ps;

	// 10 ns period
	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// reset held for 10 rising edges
	initial begin
		o_reset = 1'b1;
		repeat (10) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

//--- verilog/u3v_stream.sv
module u3v_stream #(
	parameter int PAYLOAD_CNT_WD = 24	// pixel word counter width
) (
	input  logic                     clk,
	input  logic                     reset,
	input  stream_pkg::frame_cfg_t   i_cfg,
	input  logic [63:0]              i_timestamp,	// free-running
	input  logic                     i_frame_start,
	input  stream_pkg::stream_word_t i_pixel,
	input  logic                     i_frame_end,
	output stream_pkg::stream_word_t o_stream,
	output logic                     o_busy
);
	import stream_pkg::*;

	logic         leader_flag;
	logic         chunk_flag;
	logic         trailer_flag;
	logic         chunk_done;
	frame_cfg_t   cfg_lat;	// frame-start copy of i_cfg
	frame_info_t  info;
	stream_word_t leader_word;
	stream_word_t chunk_word;
	stream_word_t trailer_word;

	// ----------------------------------------
	// sequencer and block generators
	// ----------------------------------------
	frame_sequencer #(
		.PAYLOAD_CNT_WD(PAYLOAD_CNT_WD)
	) u_seq (
		.clk            (clk),
		.reset          (reset),
		.i_cfg          (i_cfg),
		.i_timestamp    (i_timestamp),
		.i_frame_start  (i_frame_start),
		.i_pixel        (i_pixel),
		.i_frame_end    (i_frame_end),
		.i_leader_word  (leader_word),
		.i_chunk_word   (chunk_word),
		.i_trailer_word (trailer_word),
		.i_chunk_done   (chunk_done),
		.o_leader_flag  (leader_flag),
		.o_chunk_flag   (chunk_flag),
		.o_trailer_flag (trailer_flag),
		.o_cfg          (cfg_lat),
		.o_info         (info),
		.o_stream       (o_stream),
		.o_busy         (o_busy)
	);

	u3v_leader u_leader (
		.clk           (clk),
		.reset         (reset),
		.i_leader_flag (leader_flag),
		.i_cfg         (cfg_lat),
		.i_info        (info),
		.o_word        (leader_word)
	);

	// layout id follows the live enables
	u3v_trailer u_trailer (
		.clk            (clk),
		.reset          (reset),
		.i_trailer_flag (trailer_flag),
		.i_cfg          (i_cfg),
		.i_info         (info),
		.o_word         (trailer_word)
	);

	chunk_appender u_chunk (
		.clk          (clk),
		.reset        (reset),
		.i_chunk_flag (chunk_flag),
		.i_cfg        (cfg_lat),
		.i_info       (info),
		.o_word       (chunk_word),
		.o_chunk_done (chunk_done)
	);

endmodule

//--- verilog/frame_sequencer.sv
module frame_sequencer #(
	parameter int PAYLOAD_CNT_WD = 24
) (
	input  logic                     clk,
	input  logic                     reset,
	input  stream_pkg::frame_cfg_t   i_cfg,
	input  logic [63:0]              i_timestamp,
	input  logic                     i_frame_start,	// pulse
	input  stream_pkg::stream_word_t i_pixel,
	input  logic                     i_frame_end,	// with the last pixel word
	input  stream_pkg::stream_word_t i_leader_word,
	input  stream_pkg::stream_word_t i_chunk_word,
	input  stream_pkg::stream_word_t i_trailer_word,
	input  logic                     i_chunk_done,
	output logic                     o_leader_flag,
	output logic                     o_chunk_flag,
	output logic                     o_trailer_flag,
	output stream_pkg::frame_cfg_t   o_cfg,
	output stream_pkg::frame_info_t  o_info,
	output stream_pkg::stream_word_t o_stream,
	output logic                     o_busy
);
	import stream_pkg::*;
	import u3v_pkg::*;

	localparam logic [3:0] TRAILER_HOLD = 4'd10;	// flag cycles per trailer

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LEADER,
		ST_PAYLOAD,
		ST_CHUNK,
		ST_TRAILER
	} phase_t;

	phase_t                    state;
	logic [3:0]                phase_cnt;	// flag hold counter
	logic [PAYLOAD_CNT_WD-1:0] pay_cnt;
	logic [PAYLOAD_CNT_WD-1:0] pay_cnt_nxt;
	logic                      start_ok;
	logic                      frame_done;	// end pulse seen in payload phase
	frame_cfg_t                cfg_r;
	logic [63:0]               block_id;
	logic [63:0]               ts_r;
	logic [15:0]               status_r;
	logic [31:0]               vps_r;
	stream_word_t              pixel_r;
	stream_word_t              merged;

	assign start_ok = i_frame_start && !o_busy;	// ignored mid-frame
	assign frame_done = (state == ST_PAYLOAD) && i_frame_end;
	assign pay_cnt_nxt = pay_cnt + PAYLOAD_CNT_WD'(i_pixel.valid);

	// ----------------------------------------
	// frame phase FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			phase_cnt <= 4'd0;
			pay_cnt <= '0;
			block_id <= 64'd0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_ok) begin
						state <= ST_LEADER;
						phase_cnt <= 4'd0;
						pay_cnt <= '0;
					end
				end
				ST_LEADER: begin
					phase_cnt <= phase_cnt + 4'd1;
					if (phase_cnt == 4'(LEADER_WORDS)) begin	// 14th flag cycle
						state <= ST_PAYLOAD;
					end
				end
				ST_PAYLOAD: begin
					pay_cnt <= pay_cnt_nxt;
					if (i_frame_end) begin
						phase_cnt <= 4'd0;
						state <= cfg_r.chunk_mode_active ? ST_CHUNK : ST_TRAILER;
					end
				end
				ST_CHUNK: begin
					if (i_chunk_done) begin
						phase_cnt <= 4'd0;
						state <= ST_TRAILER;
					end
				end
				ST_TRAILER: begin
					phase_cnt <= phase_cnt + 4'd1;
					if (phase_cnt == TRAILER_HOLD - 4'd1) begin
						state <= ST_IDLE;
						block_id <= block_id + 64'd1;	// next frame
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// per-frame latches
	always_ff @(posedge clk) begin
		if (start_ok) begin
			cfg_r <= i_cfg;
			ts_r <= i_timestamp;
		end
		if (frame_done) begin
			vps_r <= 32'({pay_cnt_nxt, 2'b00});	// bytes
			status_r <= (32'(pay_cnt_nxt) < cfg_r.expected_words) ? STATUS_SHORT : STATUS_OK;
		end
	end

	assign o_leader_flag = (state == ST_LEADER);
	assign o_chunk_flag = (state == ST_CHUNK);
	assign o_trailer_flag = (state == ST_TRAILER);
	assign o_cfg = cfg_r;
	assign o_info = '{block_id: block_id, timestamp: ts_r, status: status_r,
		valid_payload_size: vps_r};

	// ----------------------------------------
	// output merge
	// ----------------------------------------
	assign merged.valid = i_leader_word.valid | i_chunk_word.valid
		| i_trailer_word.valid | pixel_r.valid;
	assign merged.data = ({32{i_leader_word.valid}} & i_leader_word.data)
		| ({32{i_chunk_word.valid}} & i_chunk_word.data)
		| ({32{i_trailer_word.valid}} & i_trailer_word.data)
		| ({32{pixel_r.valid}} & pixel_r.data);

	always_ff @(posedge clk) begin
		pixel_r.data <= i_pixel.data;
		o_stream.data <= merged.data;
		if (reset) begin
			pixel_r.valid <= 1'b0;
			o_stream.valid <= 1'b0;
		end else begin
			pixel_r.valid <= i_pixel.valid && (state == ST_PAYLOAD);	// 2 cycle path
			o_stream.valid <= merged.valid;
		end
	end

	// last trailer words still draining after the FSM went idle
	assign o_busy = (state != ST_IDLE) || o_stream.valid;

	a_one_source: assert property (@(posedge clk) disable iff (reset)
		$onehot0({i_leader_word.valid, i_chunk_word.valid, i_trailer_word.valid, pixel_r.valid}));

endmodule

//--- verilog/chunk_appender.sv
module chunk_appender (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     i_chunk_flag,	// held until done is seen
	input  stream_pkg::frame_cfg_t   i_cfg,
	input  stream_pkg::frame_info_t  i_info,
	output stream_pkg::stream_word_t o_word,
	output logic                     o_chunk_done
);
	import u3v_pkg::*;

	logic [3:0]  count;
	logic [3:0]  chunk_len;	// 2, 6 or 10 words
	logic [3:0]  opt_pos;	// position inside the optional chunks
	logic        opt_fid;	// slot belongs to the frame id chunk
	logic [31:0] opt_word;
	logic [31:0] word_d;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= 4'd0;
		end else if (i_chunk_flag) begin
			count <= count + 4'd1;
		end else begin
			count <= 4'd0;
		end
	end

	// ----------------------------------------
	// word select
	// ----------------------------------------
	assign chunk_len = 4'd2 + (i_cfg.chunkid_en_ts ? 4'd4 : 4'd0)
		+ (i_cfg.chunkid_en_fid ? 4'd4 : 4'd0);
	assign opt_pos = count - 4'd3;
	assign opt_fid = opt_pos[2] | ~i_cfg.chunkid_en_ts;	// ts chunk comes first when on

	always_comb begin
		case (opt_pos[1:0])
			2'd0:    opt_word = opt_fid ? i_info.block_id[31:0] : i_info.timestamp[31:0];
			2'd1:    opt_word = opt_fid ? i_info.block_id[63:32] : i_info.timestamp[63:32];
			2'd2:    opt_word = opt_fid ? CHUNK_ID_FID : CHUNK_ID_TS;
			default: opt_word = CHUNK_DATA_LEN;
		endcase
	end

	always_comb begin
		if (count == 4'd1) begin
			word_d = CHUNK_ID_IMAGE;	// image chunk tag
		end else if (count == 4'd2) begin
			word_d = i_info.valid_payload_size;
		end else begin
			word_d = opt_word;
		end
	end

	always_ff @(posedge clk) begin
		o_word.data <= word_d;
		if (reset) begin
			o_word.valid <= 1'b0;
			o_chunk_done <= 1'b0;
		end else begin
			o_word.valid <= (count != 4'd0) && (count <= chunk_len);
			o_chunk_done <= (count != 4'd0) && (count == chunk_len);	// with the last word
		end
	end

	a_done_in_flag: assert property (@(posedge clk) disable iff (reset)
		o_chunk_done |-> i_chunk_flag);

endmodule

//--- header_gen/u3v_trailer.sv
module u3v_trailer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     i_trailer_flag,	// level, held 10 cycles
	input  stream_pkg::frame_cfg_t   i_cfg,	// live config, not the latched copy
	input  stream_pkg::frame_info_t  i_info,
	output stream_pkg::stream_word_t o_word
);
	import u3v_pkg::*;

	logic [3:0]  count;
	logic [2:0]  en_now;
	logic [2:0]  en_prev;	// enables one cycle earlier
	logic [7:0]  layout_id;
	logic [31:0] word_d;
	logic [3:0]  last_word;
	logic        word_vld;

	// ----------------------------------------
	// chunk layout id
	// ----------------------------------------
	assign en_now = {i_cfg.chunk_mode_active, i_cfg.chunkid_en_ts, i_cfg.chunkid_en_fid};

	always_ff @(posedge clk) begin
		en_prev <= en_now;	// tracks during reset too
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			layout_id <= 8'd0;
		end else if (en_now != en_prev) begin
			layout_id <= layout_id + 8'd1;	// wraps at 256
		end
	end

	// flag cycle counter, cleared when the flag falls
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= 4'd0;
		end else if (i_trailer_flag) begin
			count <= count + 4'd1;
		end else begin
			count <= 4'd0;
		end
	end

	// 9th word only in chunk mode
	assign last_word = i_cfg.chunk_mode_active ? 4'(TRAILER_WORDS_CHUNK) : 4'(TRAILER_WORDS_IMG);
	assign word_vld = (count != 4'd0) && (count <= last_word);

	always_comb begin
		case (count)
			4'd1:    word_d = TRAILER_MAGIC;
			4'd2:    word_d = {(i_cfg.chunk_mode_active ? TRAILER_BYTES_CHUNK : TRAILER_BYTES_IMG),
				16'h0000};
			4'd3:    word_d = i_info.block_id[31:0];
			4'd4:    word_d = i_info.block_id[63:32];
			4'd5:    word_d = {16'h0000, i_info.status};
			4'd6:    word_d = i_info.valid_payload_size;
			4'd7:    word_d = 32'h0;	// reserved
			4'd8:    word_d = {16'h0000, i_cfg.size_y};
			4'd9:    word_d = {24'h0, layout_id};
			default: word_d = 32'h0;
		endcase
	end

	always_ff @(posedge clk) begin
		o_word.data <= word_d;
		if (reset) begin
			o_word.valid <= 1'b0;
		end else begin
			o_word.valid <= word_vld;
		end
	end

	// trailer flag comes from the sequencer, fixed hold of 10
	a_count_max: assert property (@(posedge clk) disable iff (reset) count <= 4'd10);

endmodule

//--- header_gen/u3v_leader.sv
module u3v_leader (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     i_leader_flag,	// level, held 14 cycles
	input  stream_pkg::frame_cfg_t   i_cfg,	// latched copy
	input  stream_pkg::frame_info_t  i_info,
	output stream_pkg::stream_word_t o_word
);
	import u3v_pkg::*;

	logic [3:0]  count;	// cycles the flag has been seen
	logic [31:0] word_d;
	logic [15:0] payload_type;
	logic        word_vld;

	// ----------------------------------------
	// flag cycle counter
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= 4'd0;
		end else if (i_leader_flag) begin
			count <= count + 4'd1;
		end else begin
			count <= 4'd0;	// ready for the next leader
		end
	end

	assign payload_type = i_cfg.chunk_mode_active ? PAYLOAD_CHUNK : PAYLOAD_IMAGE;
	assign word_vld = (count != 4'd0) && (count <= 4'(LEADER_WORDS));

	// leader field select, one word per count
	always_comb begin
		case (count)
			4'd1:    word_d = LEADER_MAGIC;
			4'd2:    word_d = {LEADER_BYTES, 16'h0000};	// size in upper half
			4'd3:    word_d = i_info.block_id[31:0];
			4'd4:    word_d = i_info.block_id[63:32];
			4'd5:    word_d = {16'h0000, payload_type};
			4'd6:    word_d = i_info.timestamp[31:0];
			4'd7:    word_d = i_info.timestamp[63:32];
			4'd8:    word_d = i_cfg.pixel_format;
			4'd9:    word_d = {16'h0000, i_cfg.size_x};
			4'd10:   word_d = {16'h0000, i_cfg.size_y};
			4'd11:   word_d = {16'h0000, i_cfg.offset_x};
			4'd12:   word_d = {16'h0000, i_cfg.offset_y};
			4'd13:   word_d = {16'h0000, i_cfg.padding_x};
			default: word_d = 32'h0;
		endcase
	end

	// output register
	always_ff @(posedge clk) begin
		o_word.data <= word_d;
		if (reset) begin
			o_word.valid <= 1'b0;
		end else begin
			o_word.valid <= word_vld;
		end
	end

	// sequencer must drop the flag well before the counter wraps
	a_flag_len: assert property (@(posedge clk) disable iff (reset)
		!(i_leader_flag && (count == 4'hF)));

endmodule

//--- common/stream_pkg.sv
package stream_pkg;

	// ----------------------------------------
	// one 32-bit word of the output stream
	// ----------------------------------------
	typedef struct packed {
		logic        valid;	// qualifies data, no handshake
		logic [31:0] data;
	} stream_word_t;

	// static settings for one frame
	// sampled by the sequencer at frame start
	typedef struct packed {
		logic        chunk_mode_active;	// payload type 0x4001 when set
		logic        chunkid_en_ts;	// append timestamp chunk
		logic        chunkid_en_fid;	// append frame id chunk
		logic [31:0] pixel_format;
		logic [15:0] size_x;
		logic [15:0] size_y;
		logic [15:0] offset_x;
		logic [15:0] offset_y;
		logic [15:0] padding_x;
		logic [31:0] expected_words;	// pixel words for a full frame
	} frame_cfg_t;

	// ----------------------------------------
	// per-frame values kept by the sequencer
	// ----------------------------------------
	typedef struct packed {
		logic [63:0] block_id;	// 0 for the first frame after reset
		logic [63:0] timestamp;	// taken at frame start
		logic [15:0] status;
		logic [31:0] valid_payload_size;	// bytes, 4 per pixel word
	} frame_info_t;

endpackage

//--- common/u3v_pkg.sv
package u3v_pkg;

	// ----------------------------------------
	// block framing
	// ----------------------------------------
	localparam logic [31:0] LEADER_MAGIC  = 32'h4C56_3355;	// "U3VL", little endian
	localparam logic [31:0] TRAILER_MAGIC = 32'h5456_3355;	// "U3VT"

	localparam int LEADER_WORDS = 13;	// words in one leader block
	localparam logic [15:0] LEADER_BYTES = 16'd52;

	// trailer length depends on the payload type
	localparam int TRAILER_WORDS_IMG   = 8;
	localparam int TRAILER_WORDS_CHUNK = 9;	// extra word carries the chunk layout id
	localparam logic [15:0] TRAILER_BYTES_IMG   = 16'd32;
	localparam logic [15:0] TRAILER_BYTES_CHUNK = 16'd36;

	// ----------------------------------------
	// payload types, as in the leader
	// ----------------------------------------
	localparam logic [15:0] PAYLOAD_IMAGE = 16'h0001;
	localparam logic [15:0] PAYLOAD_CHUNK = 16'h4001;	// image extended chunk

	// chunk tags, id word then length word
	localparam logic [31:0] CHUNK_ID_IMAGE = 32'h0000_A001;
	localparam logic [31:0] CHUNK_ID_TS    = 32'h0000_A002;	// timestamp chunk
	localparam logic [31:0] CHUNK_ID_FID   = 32'h0000_A003;	// frame id chunk
	localparam logic [31:0] CHUNK_DATA_LEN = 32'd8;	// both optional chunks carry 64 bits

	// ----------------------------------------
	// trailer status codes
	// ----------------------------------------
	localparam logic [15:0] STATUS_OK    = 16'h0000;
	localparam logic [15:0] STATUS_SHORT = 16'hA101;	// frame ended before expected_words

endpackage
